/* src.f */
+incdir+.
id_pkg.sv
inst_decoder.sv
imm_gen.sv
operand_forward.sv
id_ex_reg.sv
id_stage.sv
tb_id_stage.sv

/* tb_id_ref.svh */
`ifndef TB_ID_REF_SVH
`define TB_ID_REF_SVH

function automatic logic [31:0] next_rand(); // xorshift32
	rng_state = rng_state ^ (rng_state << 13);
	rng_state = rng_state ^ (rng_state >> 17);
	rng_state = rng_state ^ (rng_state << 5);
	return rng_state;
endfunction

// legality straight from the encoding table
function automatic logic ref_legal(input logic [31:0] w);
	logic [2:0] f3;
	logic [6:0] f7;
	f3 = w[14:12];
	f7 = w[31:25];
	case (w[6:0])
		7'b0110011: return f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))
			|| (f7 == 7'h01 && f3 == 3'd0);
		7'b0010011: return f3 != 3'd5 || w[31:26] == 6'h00 || w[31:26] == 6'h10;
		7'b0011011: return f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5;
		7'b0111011: return (f7 == 7'h00 && (f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5))
			|| (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
		7'b0100011: return f3 <= 3'd3; // store
		7'b0000011: return f3 <= 3'd4; // load
		7'b1100011: return f3 != 3'd2 && f3 != 3'd3 && f3 != 3'd5;
		7'b1101111, 7'b1100111, 7'b0110111, 7'b0010111: return 1'b1;
		default: return 1'b0;
	endcase
endfunction

// sign-extend the low w bits, upper bits of v must be zero
function automatic logic [63:0] sext(input logic [63:0] v, input int w);
	return v[w-1] ? (v | ({64{1'b1}} << w)) : v;
endfunction

function automatic logic [63:0] ref_imm(input logic [31:0] w);
	case (w[6:0])
		7'b0010011, 7'b0011011, 7'b0000011, 7'b1100111: return sext(w[31:20], 12);
		7'b0100011: return sext({w[31:25], w[11:7]}, 12);
		7'b1100011: return sext({w[31], w[7], w[30:25], w[11:8], 1'b0}, 13);
		7'b0110111, 7'b0010111: return sext({w[31:12], 12'h000}, 32);
		7'b1101111: return sext({w[31], w[19:12], w[20], w[30:21], 1'b0}, 21);
		default: return 64'd0;
	endcase
endfunction

function automatic logic [63:0] ref_fwd(input logic [4:0] a, input logic rd,
	input logic [63:0] rf);
	if (a == 5'd0 || !rd) return 64'd0;
	if (ex_wreg_i && ex_rd_addr_i == a) return ex_wdata_i; // youngest first
	if (mem_wreg_i && mem_rd_addr_i == a) return mem_wdata_i;
	if (wb_wreg_i && wb_rd_addr_i == a) return wb_wdata_i;
	return rf;
endfunction

// expected ID/EX contents after the edge that sees these inputs
function automatic void ref_decode(input logic [31:0] w, input logic [63:0] pc, input logic rst);
	logic       legal;
	logic       rd1;
	logic       rd2;
	logic [6:0] opc;
	opc   = w[6:0];
	legal = ref_legal(w);
	rd1   = legal && opc != 7'b1101111 && opc != 7'b0110111 && opc != 7'b0010111;
	rd2   = legal && (opc == 7'b0110011 || opc == 7'b0111011 || opc == 7'b0100011
		|| opc == 7'b1100011);
	exp_wreg   = !rst && legal && opc != 7'b0100011 && opc != 7'b1100011;
	exp_ill    = !rst && !legal;
	exp_r1     = !rst && rd1;
	exp_r2     = !rst && rd2;
	exp_opcode = (rst || !legal) ? 7'd0 : opc;
	exp_f3     = (rst || !legal) ? 3'd0 : w[14:12];
	exp_f7     = (rst || !legal) ? 7'd0 : w[31:25];
	exp_rd     = rst ? 5'd0 : w[11:7];
	exp_d1     = rst ? 64'd0 : ref_fwd(w[19:15], rd1, rs1_data_i);
	exp_d2     = rst ? 64'd0 : ref_fwd(w[24:20], rd2, rs2_data_i);
	exp_imm    = rst ? 64'd0 : ref_imm(w);
	exp_pc     = rst ? 64'd0 : pc;
endfunction

task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
	n_checks++;
	if (got !== exp) begin
		n_errors++;
		$display("** Error %s: got %h, expected %h at %0t", name, got, exp, $time);
	end
endtask

`endif

/* tb_id_stage.sv */
`timescale 1ns/1ps

module tb_id_stage;

	localparam int N_RESET = 8;
	localparam int N_LEGAL = 220;
	localparam int N_RAND  = 300;
	localparam int N_IMM   = 40;
	localparam int N_FWD   = 12;
	localparam int N_PC    = 20;
	localparam int N_TOTAL = N_RESET + N_LEGAL + N_RAND + N_IMM + N_FWD + N_PC;

	logic        clk;
	logic        rst_i;
	logic [31:0] inst_i;
	logic [63:0] pc_i, rs1_data_i, rs2_data_i, ex_wdata_i, mem_wdata_i, wb_wdata_i;
	logic [4:0]  ex_rd_addr_i, mem_rd_addr_i, wb_rd_addr_i;
	logic        ex_wreg_i, mem_wreg_i, wb_wreg_i;
	logic [4:0]  rs1_addr_o, rs2_addr_o, rd_addr_o;
	logic [6:0]  opcode_o, funct7_o;
	logic [2:0]  funct3_o;
	logic [63:0] rs1_data_o, rs2_data_o, imm_o, pc_o;
	logic        wreg_o, rs1_read_o, rs2_read_o, illegal_o;
	logic [6:0]  exp_opcode, exp_f7; // filled by ref_decode
	logic [2:0]  exp_f3;
	logic [4:0]  exp_rd;
	logic        exp_wreg, exp_r1, exp_r2, exp_ill;
	logic [63:0] exp_d1, exp_d2, exp_imm, exp_pc;
	logic [31:0] rng_state = 32'hc623_5baa;
	int          n_checks = 0;
	int          n_errors = 0;
	int          err_base = 0; // error count at test start
	logic [6:0]  opcodes [11] = '{7'b0110011, 7'b0010011, 7'b0011011, 7'b0111011,
		7'b0000011, 7'b0100011, 7'b1100011, 7'b1101111, 7'b1100111, 7'b0110111, 7'b0010111};
	logic [6:0]  fmts [5] = '{7'b0010011, 7'b0100011, 7'b1100011, 7'b0110111, 7'b1101111};

	`include "tb_id_ref.svh"

	id_stage i_dut (.*);

	always #50 clk = ~clk;

	// random word of a given opcode, retried until the table accepts it
	function automatic logic [31:0] legal_word(input logic [6:0] opc);
		logic [31:0] w;
		logic [31:0] r;
		do begin
			w = next_rand();
			r = next_rand();
			w[6:0] = opc;
			case (r[1:0]) // base, mul, alt, alt with shamt bit 5
				2'd0: w[31:25] = 7'h00;
				2'd1: w[31:25] = 7'h01;
				2'd2: w[31:25] = 7'h20;
				default: w[31:25] = 7'h21;
			endcase
		end while (!ref_legal(w));
		return w;
	endfunction

	task automatic drive(input logic [31:0] w);
		logic [31:0] r;
		@(posedge clk);
		r = next_rand();
		inst_i        <= w;
		pc_i          <= {next_rand(), next_rand()};
		rs1_data_i    <= {next_rand(), next_rand()};
		rs2_data_i    <= {next_rand(), next_rand()};
		ex_wdata_i    <= {next_rand(), next_rand()};
		mem_wdata_i   <= {next_rand(), next_rand()};
		wb_wdata_i    <= {next_rand(), next_rand()};
		ex_rd_addr_i  <= r[4:0];
		mem_rd_addr_i <= r[9:5];
		wb_rd_addr_i  <= r[14:10];
		ex_wreg_i     <= r[15];
		mem_wreg_i    <= r[16];
		wb_wreg_i     <= r[17];
	endtask

	task automatic finish_test(input string name, input int vecs);
		repeat (2) @(posedge clk); // last vector captured and compared
		$display("test %-8s %0d vectors, %0d errors", name, vecs, n_errors - err_base);
		err_base = n_errors;
	endtask

	// compare one cycle after each edge, outputs settled at negedge
	always begin
		@(posedge clk);
		ref_decode(inst_i, pc_i, rst_i); // still the pre-edge inputs
		@(negedge clk);
		check("opcode_o", opcode_o, exp_opcode);
		check("funct3_o", funct3_o, exp_f3);
		check("funct7_o", funct7_o, exp_f7);
		check("rd_addr_o", rd_addr_o, exp_rd);
		check("wreg_o", wreg_o, exp_wreg);
		check("rs1_read_o", rs1_read_o, exp_r1);
		check("rs2_read_o", rs2_read_o, exp_r2);
		check("illegal_o", illegal_o, exp_ill);
		check("rs1_data_o", rs1_data_o, exp_d1);
		check("rs2_data_o", rs2_data_o, exp_d2);
		check("imm_o", imm_o, exp_imm);
		check("pc_o", pc_o, exp_pc);
		check("rs1_addr_o", rs1_addr_o, inst_i[19:15]); // same cycle, no register
		check("rs2_addr_o", rs2_addr_o, inst_i[24:20]);
	end

	initial begin
		#((N_TOTAL + 12 + 20) * 100);
		$display("watchdog expired before the stimulus finished");
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		logic [31:0] w;
		logic [31:0] r;
		logic [4:0]  a;
		clk = 1'b0;
		rst_i = 1'b1;
		inst_i = '0;
		pc_i = '0;
		rs1_data_i = '0;
		rs2_data_i = '0;
		ex_wdata_i = '0;
		mem_wdata_i = '0;
		wb_wdata_i = '0;
		ex_rd_addr_i = '0;
		mem_rd_addr_i = '0;
		wb_rd_addr_i = '0;
		ex_wreg_i = 1'b0;
		mem_wreg_i = 1'b0;
		wb_wreg_i = 1'b0;
		for (int i = 0; i < N_RESET; i++) begin
			drive(legal_word(opcodes[i % 11])); // busy inputs, reset must win
			if (i == N_RESET - 1) rst_i <= 1'b0;
		end
		finish_test("reset", N_RESET);
		for (int i = 0; i < N_LEGAL; i++) drive(legal_word(opcodes[i % 11]));
		finish_test("legal", N_LEGAL);
		for (int i = 0; i < N_RAND; i++) begin
			w = next_rand();
			r = next_rand();
			if (r[0]) w[6:0] = opcodes[r[4:1] % 11]; // known opcode, random functs
			drive(w);
		end
		finish_test("random", N_RAND);
		for (int i = 0; i < N_IMM; i++) begin
			w = legal_word(fmts[i % 5]);
			w[31] = (i % 2 == 1); // both signs per format
			drive(w);
		end
		finish_test("imm", N_IMM);
		for (int c = 0; c < N_FWD; c++) begin
			r = next_rand();
			a = (c % 6 == 4) ? 5'd0 : ((r[4:0] == 5'd0) ? 5'd5 : r[4:0]);
			if (c % 6 == 5) w = {7'h00, a ^ 5'd1, a, 3'b000, r[9:5], 7'b0110111}; // lui, no reads
			else w = {7'h00, a ^ 5'd1, a, 3'b000, r[9:5], 7'b0110011}; // add, rs2 from regfile
			drive(w);
			ex_rd_addr_i  <= a; // overrides the random triples
			mem_rd_addr_i <= a;
			wb_rd_addr_i  <= a;
			ex_wreg_i     <= (c % 6 == 0 || c % 6 >= 4);
			mem_wreg_i    <= (c % 6 <= 1 || c % 6 >= 4);
			wb_wreg_i     <= (c % 6 <= 2 || c % 6 >= 4);
		end
		finish_test("forward", N_FWD);
		for (int i = 0; i < N_PC; i++) drive(next_rand());
		finish_test("addr/pc", N_PC);
		$display("%0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0) $display("RESULT: PASS");
		else $display("RESULT: FAIL");
		$finish;
	end

endmodule

/* id_stage.sv */
`timescale 1ns/1ps

module id_stage import id_pkg::*; (
	input  logic      clk,
	input  logic      rst_i,         // sync, active high
	input  inst_t     inst_i,        // instruction from fetch
	input  addr_t     pc_i,          // pc of inst_i
	input  reg_data_t rs1_data_i,    // regfile port 1
	input  reg_data_t rs2_data_i,    // regfile port 2
	input  reg_data_t ex_wdata_i,    // forward from EX
	input  reg_data_t mem_wdata_i,   // forward from MEM
	input  reg_data_t wb_wdata_i,    // forward from MEM/WB
	input  reg_addr_t ex_rd_addr_i,
	input  reg_addr_t mem_rd_addr_i,
	input  reg_addr_t wb_rd_addr_i,
	input  logic      ex_wreg_i,
	input  logic      mem_wreg_i,
	input  logic      wb_wreg_i,
	output reg_addr_t rs1_addr_o,    // to regfile, same cycle
	output reg_addr_t rs2_addr_o,    // to regfile, same cycle
	output opcode_t   opcode_o,
	output funct3_t   funct3_o,
	output funct7_t   funct7_o,
	output reg_data_t rs1_data_o,
	output reg_data_t rs2_data_o,
	output reg_addr_t rd_addr_o,
	output logic      wreg_o,
	output logic      rs1_read_o,
	output logic      rs2_read_o,
	output logic      illegal_o,
	output reg_data_t imm_o,
	output addr_t     pc_o
);

	opcode_t   dec_opcode;
	funct3_t   dec_funct3;
	funct7_t   dec_funct7;
	logic      dec_wreg;
	logic      dec_rs1_read;
	logic      dec_rs2_read;
	logic      dec_illegal;
	reg_data_t dec_imm;
	reg_data_t fwd_rs1_data;
	reg_data_t fwd_rs2_data;
	reg_addr_t rd_addr;

	assign rs1_addr_o = inst_i[19:15]; // raw fields, read flags decide use
	assign rs2_addr_o = inst_i[24:20];
	assign rd_addr    = inst_i[11:7];

	inst_decoder i_inst_decoder (
		.inst_i     (inst_i),
		.opcode_o   (dec_opcode),
		.funct3_o   (dec_funct3),
		.funct7_o   (dec_funct7),
		.wreg_o     (dec_wreg),
		.rs1_read_o (dec_rs1_read),
		.rs2_read_o (dec_rs2_read),
		.illegal_o  (dec_illegal)
	);

	imm_gen i_imm_gen (
		.inst_i (inst_i),
		.imm_o  (dec_imm)
	);

	operand_forward i_fwd_rs1 (
		.rs_addr_i     (rs1_addr_o),
		.rs_read_i     (dec_rs1_read),
		.rf_data_i     (rs1_data_i),
		.ex_wdata_i    (ex_wdata_i),
		.ex_rd_addr_i  (ex_rd_addr_i),
		.ex_wreg_i     (ex_wreg_i),
		.mem_wdata_i   (mem_wdata_i),
		.mem_rd_addr_i (mem_rd_addr_i),
		.mem_wreg_i    (mem_wreg_i),
		.wb_wdata_i    (wb_wdata_i),
		.wb_rd_addr_i  (wb_rd_addr_i),
		.wb_wreg_i     (wb_wreg_i),
		.rs_data_o     (fwd_rs1_data)
	);

	operand_forward i_fwd_rs2 (
		.rs_addr_i     (rs2_addr_o),
		.rs_read_i     (dec_rs2_read),
		.rf_data_i     (rs2_data_i),
		.ex_wdata_i    (ex_wdata_i),
		.ex_rd_addr_i  (ex_rd_addr_i),
		.ex_wreg_i     (ex_wreg_i),
		.mem_wdata_i   (mem_wdata_i),
		.mem_rd_addr_i (mem_rd_addr_i),
		.mem_wreg_i    (mem_wreg_i),
		.wb_wdata_i    (wb_wdata_i),
		.wb_rd_addr_i  (wb_rd_addr_i),
		.wb_wreg_i     (wb_wreg_i),
		.rs_data_o     (fwd_rs2_data)
	);

	id_ex_reg i_id_ex_reg (
		.clk        (clk),
		.rst_i      (rst_i),
		.opcode_i   (dec_opcode),
		.funct3_i   (dec_funct3),
		.funct7_i   (dec_funct7),
		.rd_addr_i  (rd_addr),
		.wreg_i     (dec_wreg),
		.rs1_read_i (dec_rs1_read),
		.rs2_read_i (dec_rs2_read),
		.illegal_i  (dec_illegal),
		.rs1_data_i (fwd_rs1_data),
		.rs2_data_i (fwd_rs2_data),
		.imm_i      (dec_imm),
		.pc_i       (pc_i),
		.opcode_o   (opcode_o),
		.funct3_o   (funct3_o),
		.funct7_o   (funct7_o),
		.rd_addr_o  (rd_addr_o),
		.wreg_o     (wreg_o),
		.rs1_read_o (rs1_read_o),
		.rs2_read_o (rs2_read_o),
		.illegal_o  (illegal_o),
		.rs1_data_o (rs1_data_o),
		.rs2_data_o (rs2_data_o),
		.imm_o      (imm_o),
		.pc_o       (pc_o)
	);

endmodule

/* id_ex_reg.sv */
`timescale 1ns/1ps

module id_ex_reg import id_pkg::*; (
	input  logic      clk,
	input  logic      rst_i,        // sync, active high
	input  opcode_t   opcode_i,
	input  funct3_t   funct3_i,
	input  funct7_t   funct7_i,
	input  reg_addr_t rd_addr_i,
	input  logic      wreg_i,
	input  logic      rs1_read_i,
	input  logic      rs2_read_i,
	input  logic      illegal_i,
	input  reg_data_t rs1_data_i,   // forwarded operand
	input  reg_data_t rs2_data_i,
	input  reg_data_t imm_i,
	input  addr_t     pc_i,
	output opcode_t   opcode_o,
	output funct3_t   funct3_o,
	output funct7_t   funct7_o,
	output reg_addr_t rd_addr_o,
	output logic      wreg_o,
	output logic      rs1_read_o,
	output logic      rs2_read_o,
	output logic      illegal_o,
	output reg_data_t rs1_data_o,
	output reg_data_t rs2_data_o,
	output reg_data_t imm_o,
	output addr_t     pc_o
);

	// captures every edge, no stall path
	always_ff @(posedge clk) begin
		if (rst_i) begin
			opcode_o   <= '0;
			funct3_o   <= '0;
			funct7_o   <= '0;
			rd_addr_o  <= '0;
			wreg_o     <= 1'b0; // no write back out of reset
			rs1_read_o <= 1'b0;
			rs2_read_o <= 1'b0;
			illegal_o  <= 1'b0; // bubble, not a trap
			rs1_data_o <= '0;
			rs2_data_o <= '0;
			imm_o      <= '0;
			pc_o       <= '0;
		end else begin
			opcode_o   <= opcode_i;
			funct3_o   <= funct3_i;
			funct7_o   <= funct7_i;
			rd_addr_o  <= rd_addr_i;
			wreg_o     <= wreg_i;
			rs1_read_o <= rs1_read_i;
			rs2_read_o <= rs2_read_i;
			illegal_o  <= illegal_i;
			rs1_data_o <= rs1_data_i;
			rs2_data_o <= rs2_data_i;
			imm_o      <= imm_i;
			pc_o       <= pc_i;
		end
	end

	// a trapping slot in EX must never write back
	assert property (@(posedge clk) illegal_o |-> !wreg_o)
		else $error("id_ex_reg: wreg active on an illegal instruction");

endmodule

/* operand_forward.sv */
`timescale 1ns/1ps

module operand_forward import id_pkg::*; (
	input  reg_addr_t rs_addr_i,     // source register index
	input  logic      rs_read_i,     // operand actually used
	input  reg_data_t rf_data_i,     // regfile read data
	input  reg_data_t ex_wdata_i,    // result leaving EX
	input  reg_addr_t ex_rd_addr_i,
	input  logic      ex_wreg_i,
	input  reg_data_t mem_wdata_i,   // result leaving MEM
	input  reg_addr_t mem_rd_addr_i,
	input  logic      mem_wreg_i,
	input  reg_data_t wb_wdata_i,    // MEM/WB register, not yet in regfile
	input  reg_addr_t wb_rd_addr_i,
	input  logic      wb_wreg_i,
	output reg_data_t rs_data_o      // resolved operand
);

	logic ex_hit;
	logic mem_hit;
	logic wb_hit;

	assign ex_hit  = ex_wreg_i  && (ex_rd_addr_i  == rs_addr_i);
	assign mem_hit = mem_wreg_i && (mem_rd_addr_i == rs_addr_i);
	assign wb_hit  = wb_wreg_i  && (wb_rd_addr_i  == rs_addr_i);

	// youngest producer wins
	always_comb begin
		if (rs_addr_i == REG_ZERO || !rs_read_i) begin
			rs_data_o = '0; // x0 or unused operand
		end else if (ex_hit) begin
			rs_data_o = ex_wdata_i;
		end else if (mem_hit) begin
			rs_data_o = mem_wdata_i;
		end else if (wb_hit) begin
			rs_data_o = wb_wdata_i;
		end else begin
			rs_data_o = rf_data_i;
		end
	end

endmodule

/* imm_gen.sv */
`timescale 1ns/1ps

module imm_gen import id_pkg::*; (
	input  inst_t     inst_i, // instruction from fetch
	output reg_data_t imm_o   // sign-extended immediate, zero if none
);

	opcode_t opcode;
	logic    sgn; // immediate sign, always inst[31]

	assign opcode = inst_i[6:0];
	assign sgn    = inst_i[31];

	always_comb begin
		case (opcode)
			OP_IMM, OP_IMM_W, OP_LOAD, OP_JALR: begin // I format
				imm_o = {{(XLEN-12){sgn}}, inst_i[31:20]};
			end
			OP_STORE: begin // S format
				imm_o = {{(XLEN-12){sgn}}, inst_i[31:25], inst_i[11:7]};
			end
			OP_BRANCH: begin // B format, halfword offset
				imm_o = {{(XLEN-13){sgn}}, sgn, inst_i[7], inst_i[30:25],
					inst_i[11:8], 1'b0};
			end
			OP_LUI, OP_AUIPC: begin // U format, upper 20 bits
				imm_o = {{(XLEN-32){sgn}}, inst_i[31:12], 12'b0};
			end
			OP_JAL: begin // J format
				imm_o = {{(XLEN-21){sgn}}, sgn, inst_i[19:12], inst_i[20],
					inst_i[30:21], 1'b0};
			end
			default: imm_o = '0; // R types and illegal opcodes
		endcase
	end

endmodule

/* inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder import id_pkg::*; (
	input  inst_t   inst_i,     // instruction from fetch
	output opcode_t opcode_o,   // zero when illegal
	output funct3_t funct3_o,   // zero when illegal
	output funct7_t funct7_o,   // zero when illegal
	output logic    wreg_o,     // rd gets written back
	output logic    rs1_read_o, // rs1 operand in use
	output logic    rs2_read_o, // rs2 operand in use
	output logic    illegal_o   // not in the decode table
);

	opcode_t opcode;
	funct3_t funct3;
	funct7_t funct7;
	funct6_t funct6;
	logic    legal;   // encoding found in the table
	logic    wr_cls;  // class writes rd
	logic    rd1_cls; // class reads rs1
	logic    rd2_cls; // class reads rs2

	assign opcode = inst_i[6:0];
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];
	assign funct6 = inst_i[31:26]; // shamt[5] sits in bit 25

	// legality, opcode then funct3 then funct7/funct6
	always_comb begin
		legal = 1'b0;
		case (opcode)
			OP_R: begin
				case (funct3)
					3'b000: begin // add, sub, mul
						case (funct7)
							F7_BASE, F7_ALT, F7_MUL: legal = 1'b1;
							default: legal = 1'b0;
						endcase
					end
					3'b111, 3'b110, 3'b100, 3'b001, 3'b010, 3'b011: begin // and or xor sll slt sltu
						case (funct7)
							F7_BASE: legal = 1'b1;
							default: legal = 1'b0;
						endcase
					end
					3'b101: begin // srl, sra
						case (funct7)
							F7_BASE, F7_ALT: legal = 1'b1;
							default: legal = 1'b0;
						endcase
					end
					default: legal = 1'b0;
				endcase
			end
			OP_IMM: begin
				case (funct3)
					3'b101: begin // srli / srai, 6-bit shamt
						case (funct6)
							F6_SRL, F6_SRA: legal = 1'b1;
							default: legal = 1'b0;
						endcase
					end
					default: legal = 1'b1; // addi, slli, slti, sltiu, xori, ori, andi
				endcase
			end
			OP_IMM_W: begin
				case (funct3)
					3'b000, 3'b001, 3'b101: legal = 1'b1; // addiw, slliw, srliw/sraiw
					default: legal = 1'b0;
				endcase
			end
			OP_R_W: begin
				case (funct3)
					3'b000, 3'b101: begin // addw/subw, srlw/sraw
						case (funct7)
							F7_BASE, F7_ALT: legal = 1'b1;
							default: legal = 1'b0;
						endcase
					end
					3'b001: begin // sllw
						case (funct7)
							F7_BASE: legal = 1'b1;
							default: legal = 1'b0;
						endcase
					end
					default: legal = 1'b0;
				endcase
			end
			OP_STORE: begin
				case (funct3)
					3'b000, 3'b001, 3'b010, 3'b011: legal = 1'b1; // sb sh sw sd
					default: legal = 1'b0;
				endcase
			end
			OP_LOAD: begin
				case (funct3)
					3'b000, 3'b001, 3'b010, 3'b011, 3'b100: legal = 1'b1; // lb lh lw ld lbu
					default: legal = 1'b0;
				endcase
			end
			OP_BRANCH: begin
				case (funct3)
					3'b000, 3'b001, 3'b100, 3'b110, 3'b111: legal = 1'b1; // beq bne blt bltu bgeu
					default: legal = 1'b0;
				endcase
			end
			OP_JAL, OP_JALR, OP_LUI, OP_AUIPC: legal = 1'b1; // no funct check
			default: legal = 1'b0;
		endcase
	end

	// per-class register usage, gated by legal below
	always_comb begin
		wr_cls  = 1'b0;
		rd1_cls = 1'b0;
		rd2_cls = 1'b0;
		case (opcode)
			OP_R, OP_R_W: begin
				wr_cls  = 1'b1;
				rd1_cls = 1'b1;
				rd2_cls = 1'b1;
			end
			OP_STORE, OP_BRANCH: begin // no rd
				rd1_cls = 1'b1;
				rd2_cls = 1'b1;
			end
			OP_IMM, OP_IMM_W, OP_LOAD, OP_JALR: begin
				wr_cls  = 1'b1;
				rd1_cls = 1'b1;
			end
			OP_JAL, OP_LUI, OP_AUIPC: wr_cls = 1'b1; // pc or imm only
			default: wr_cls = 1'b0;
		endcase
	end

	assign illegal_o  = ~legal;
	assign wreg_o     = legal & wr_cls;
	assign rs1_read_o = legal & rd1_cls;
	assign rs2_read_o = legal & rd2_cls;
	assign opcode_o   = legal ? opcode : '0; // illegal decodes as all zero
	assign funct3_o   = legal ? funct3 : '0;
	assign funct7_o   = legal ? funct7 : '0;

	// legality table and class table must cover the same opcodes
	assert final (illegal_o || wr_cls || rd1_cls)
		else $error("inst_decoder: legal instruction %h has no register class", inst_i);

endmodule

/* id_pkg.sv */
package id_pkg;

	localparam int unsigned XLEN = 64; // register and data width, one word

	typedef logic [31:0]     inst_t;     // one instruction word
	typedef logic [XLEN-1:0] reg_data_t; // one register value
	typedef logic [63:0]     addr_t;     // program counter
	typedef logic [4:0]      reg_addr_t; // register index
	typedef logic [6:0]      opcode_t;   // inst[6:0]
	typedef logic [2:0]      funct3_t;   // inst[14:12]
	typedef logic [6:0]      funct7_t;   // inst[31:25]
	typedef logic [5:0]      funct6_t;   // inst[31:26], rv64 shift-immediate select

	localparam reg_addr_t REG_ZERO = 5'd0; // x0, hardwired zero

	// major opcodes of the rv64 base set plus M
	localparam opcode_t OP_R      = 7'b0110011; // add, sub, mul, logic, shifts
	localparam opcode_t OP_IMM    = 7'b0010011; // addi and friends
	localparam opcode_t OP_IMM_W  = 7'b0011011; // addiw, slliw, srliw/sraiw
	localparam opcode_t OP_R_W    = 7'b0111011; // addw, subw, sllw, srlw/sraw
	localparam opcode_t OP_LOAD   = 7'b0000011; // lb .. ld, lbu
	localparam opcode_t OP_STORE  = 7'b0100011; // sb .. sd
	localparam opcode_t OP_BRANCH = 7'b1100011; // beq, bne, blt, bltu, bgeu
	localparam opcode_t OP_JAL    = 7'b1101111;
	localparam opcode_t OP_JALR   = 7'b1100111;
	localparam opcode_t OP_LUI    = 7'b0110111;
	localparam opcode_t OP_AUIPC  = 7'b0010111;

	localparam funct7_t F7_BASE = 7'b0000000; // add, srl and the plain ops
	localparam funct7_t F7_ALT  = 7'b0100000; // sub, sra
	localparam funct7_t F7_MUL  = 7'b0000001; // M extension

	localparam funct6_t F6_SRL = 6'b000000; // srli, shamt bit 5 free
	localparam funct6_t F6_SRA = 6'b010000; // srai

endpackage
